//--- verification/bypass_golden.txt
# iv w1 d1 l1 alu1 mem1 w2 d2 l2 alu2 mem2 qv rs rt kind exp_rs exp_rt (all hex, one row per cycle)
# kind 0 no result, 1 operand, 2 stall; w/l are write enable and load flag of each slot
1 1 01 0 11111111 00000000 1 02 0 22222222 00000000 0 00 00 0 00000000 00000000
1 1 03 0 33333333 00000000 1 03 0 3333aaaa 00000000 0 00 00 0 00000000 00000000
1 1 00 0 deadbeef 00000000 1 04 1 0badf00d 44444444 0 00 00 0 00000000 00000000
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 0 00 00 0 00000000 00000000
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 0 00 00 0 00000000 00000000
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 01 02 1 11111111 22222222
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 03 00 1 3333aaaa 00000000
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 04 00 1 44444444 00000000
1 1 05 0 55550001 00000000 1 06 0 66660002 00000000 0 00 00 0 00000000 00000000
1 1 07 0 77770001 00000000 1 07 0 77770002 00000000 1 05 06 1 55550001 66660002
1 1 06 0 6666bbbb 00000000 0 00 0 00000000 00000000 1 07 05 1 77770002 55550001
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 06 07 1 6666bbbb 77770002
1 1 08 1 00000bad 88880001 1 09 0 99990001 00000000 1 06 01 1 6666bbbb 11111111
1 1 0a 0 a0a00001 00000000 1 0a 1 00000bad a0a0d002 1 08 09 2 00000000 00000000
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 08 09 1 88880001 99990001
1 1 0b 1 00000bad b1b10001 1 0c 0 c2c20001 00000000 1 0a 08 1 a0a0d002 88880001
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 0c 0b 2 00000000 00000000
1 1 00 0 ffffffff 00000000 1 0d 0 d3d30001 00000000 1 0c 0b 1 c2c20001 b1b10001
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 00 0d 1 00000000 d3d30001
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 0a 03 1 a0a0d002 3333aaaa
1 1 0e 1 00000000 e4e40001 0 00 0 00000000 00000000 0 00 00 0 00000000 00000000
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 0 0e 00 0 00000000 00000000
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 0e 00 1 e4e40001 00000000
0 0 00 0 00000000 00000000 0 00 0 00000000 00000000 1 0d 00 1 d3d30001 00000000

//--- src.f
source/bypass_pkg.sv
source/stage_slot_if.sv
source/slot_pipe.sv
source/reg_file.sv
source/forward_unit.sv
source/operand_mux.sv
source/operand_bypass_top.sv
verification/tb_operand_bypass.sv

//--- Bender.yml
package:
  name: operand_bypass

sources:
  - files:
      - source/bypass_pkg.sv
      - source/stage_slot_if.sv
      - source/slot_pipe.sv
      - source/reg_file.sv
      - source/forward_unit.sv
      - source/operand_mux.sv
      - source/operand_bypass_top.sv

  - target: simulation
    files:
      - verification/tb_operand_bypass.sv

//--- verification/tb_operand_bypass.sv
`default_nettype none

module tb_operand_bypass;
    import bypass_pkg::*;

    localparam string      GOLDEN_PATH  = "verification/bypass_golden.txt";
    localparam int         MAX_LINES    = 256;
    localparam int         IDLE_TIMEOUT = 20;
    localparam logic [1:0] KIND_OPERAND = 2'd1;
    localparam logic [1:0] KIND_STALL   = 2'd2;

    // one cycle of stimulus and the result expected one cycle later.
    typedef struct packed {
        logic       issue_valid;
        slot_t      slot_1;
        slot_t      slot_2;
        logic       query_valid;
        reg_addr_t  rs;
        reg_addr_t  rt;
        logic [1:0] kind;
        data_word_t exp_rs;
        data_word_t exp_rt;
    } row_t;

    logic       clk;
    logic       arst_n;
    logic       issue_valid;
    slot_t      issue_slot_1;
    slot_t      issue_slot_2;
    logic       query_valid;
    reg_addr_t  query_rs;
    reg_addr_t  query_rt;
    logic       operand_valid;
    data_word_t rs_value;
    data_word_t rt_value;
    logic       stall_req;

    row_t rows [$];
    int   cur_row;

    operand_bypass_top #(
        .DATA_W (32)
    ) u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .issue_valid   (issue_valid),
        .issue_slot_1  (issue_slot_1),
        .issue_slot_2  (issue_slot_2),
        .query_valid   (query_valid),
        .query_rs      (query_rs),
        .query_rt      (query_rt),
        .operand_valid (operand_valid),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .stall_req     (stall_req)
    );

    always #4 clk = ~clk;  // 8 unit period.

    // ==================================================
    // result checks
    // ==================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s row %0d got 0x%h expected 0x%h",
                                name, cur_row, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s row %0d got 0x%h expected 0x%h",
                                name, cur_row, got, exp));
        end
    endtask

    task automatic check_row(input int idx);
        row_t e;
        e       = rows[idx];
        cur_row = idx;
        check_flag("operand_valid", operand_valid, e.kind == KIND_OPERAND);
        check_flag("stall_req", stall_req, e.kind == KIND_STALL);
        if (e.kind == KIND_OPERAND) begin
            check_word("rs_value", rs_value, e.exp_rs);
            check_word("rt_value", rt_value, e.exp_rt);
        end
    endtask

    // ==================================================
    // golden file and stimulus
    // ==================================================

    function automatic slot_t make_slot(input logic [31:0] w, input logic [31:0] dst,
                                        input logic [31:0] ld, input logic [31:0] alu,
                                        input logic [31:0] mem);
        slot_t s;
        s.w_ena    = w[0];
        s.w_dst    = dst[4:0];
        s.ls_ena   = ld[0];
        s.alu_res  = alu;
        s.mem_data = mem;
        return s;
    endfunction

    task automatic load_golden();
        int          fd;
        int          n;
        int          lines;
        string       line;
        logic [31:0] fld [17];
        row_t        r;
        lines = 0;
        fd    = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            abort_run("could not open the golden file");
        end
        while (!$feof(fd)) begin
            lines++;
            if (lines > MAX_LINES) begin
                abort_run("golden file is longer than any expected run");
            end
            if ($fgets(line, fd) == 0) continue;
            if (line.len() == 0 || line[0] == "#") continue;  // column header.
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                        fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                        fld[15], fld[16]);
            if (n <= 0) continue;
            if (n != 17 || fld[14] > KIND_STALL) begin
                abort_run($sformatf("golden line %0d cannot be read as a row", lines));
            end
            r.issue_valid = fld[0][0];
            r.slot_1      = make_slot(fld[1], fld[2], fld[3], fld[4], fld[5]);
            r.slot_2      = make_slot(fld[6], fld[7], fld[8], fld[9], fld[10]);
            r.query_valid = fld[11][0];
            r.rs          = fld[12][4:0];
            r.rt          = fld[13][4:0];
            r.kind        = fld[14][1:0];
            r.exp_rs      = fld[15];
            r.exp_rt      = fld[16];
            rows.push_back(r);
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            abort_run("golden file holds no rows");
        end
    endtask

    task automatic drive_row(input row_t r);
        issue_valid  <= r.issue_valid;
        issue_slot_1 <= r.slot_1;
        issue_slot_2 <= r.slot_2;
        query_valid  <= r.query_valid;
        query_rs     <= r.rs;
        query_rt     <= r.rt;
    endtask

    task automatic wait_idle();
        for (int n = 0; n < IDLE_TIMEOUT; n++) begin
            @(negedge clk);
            if (!operand_valid && !stall_req) begin
                return;
            end
        end
        abort_run("timeout while waiting for the outputs to settle after reset");
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        issue_valid  = 1'b0;
        issue_slot_1 = '0;
        issue_slot_2 = '0;
        query_valid  = 1'b0;
        query_rs     = '0;
        query_rt     = '0;
        cur_row      = 0;
        load_golden();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        wait_idle();
        // row r is driven in cycle r and its result is seen in cycle r+1.
        for (int r = 0; r <= rows.size(); r++) begin
            @(posedge clk);
            if (r < rows.size()) begin
                drive_row(rows[r]);
            end else begin
                drive_row('0);
            end
            @(negedge clk);
            if (r > 0) begin
                check_row(r - 1);
            end
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/operand_bypass_top.sv
`default_nettype none

module operand_bypass_top #(
    parameter int DATA_W = 32
) (
    input  logic                   clk,
    input  logic                   arst_n,

    // ==================================================
    // issue, two slots into execute
    // ==================================================
    input  logic                   issue_valid,
    input  bypass_pkg::slot_t      issue_slot_1,
    input  bypass_pkg::slot_t      issue_slot_2,

    // ==================================================
    // decode query and operand result
    // ==================================================
    input  logic                   query_valid,
    input  bypass_pkg::reg_addr_t  query_rs,
    input  bypass_pkg::reg_addr_t  query_rt,
    output logic                   operand_valid,
    output bypass_pkg::data_word_t rs_value,
    output bypass_pkg::data_word_t rt_value,
    output logic                   stall_req
);
    import bypass_pkg::*;

    fwd_sel_t   fwd_rs;
    fwd_sel_t   fwd_rt;
    logic       load_use;
    data_word_t rf_rs;
    data_word_t rf_rt;

    stage_slot_if slot_bus ();

    slot_pipe u_slot_pipe (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_slot_1 (issue_slot_1),
        .issue_slot_2 (issue_slot_2),
        .slots        (slot_bus.pipe)
    );

    reg_file #(
        .DATA_W (DATA_W)
    ) u_reg_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .slots     (slot_bus.view),
        .rd_addr_1 (query_rs),
        .rd_addr_2 (query_rt),
        .rd_data_1 (rf_rs),
        .rd_data_2 (rf_rt)
    );

    forward_unit u_forward_unit (
        .slots    (slot_bus.view),
        .query_rs (query_rs),
        .query_rt (query_rt),
        .fwd_rs   (fwd_rs),
        .fwd_rt   (fwd_rt),
        .load_use (load_use)
    );

    operand_mux #(
        .DATA_W (DATA_W)
    ) u_operand_mux (
        .clk           (clk),
        .arst_n        (arst_n),
        .query_valid   (query_valid),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt),
        .load_use      (load_use),
        .slots         (slot_bus.view),
        .rf_rs         (rf_rs),
        .rf_rt         (rf_rt),
        .operand_valid (operand_valid),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .stall_req     (stall_req)
    );

endmodule

`default_nettype wire

//--- source/operand_mux.sv
`default_nettype none

module operand_mux #(
    parameter int DATA_W = 32
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   query_valid,
    input  bypass_pkg::fwd_sel_t   fwd_rs,
    input  bypass_pkg::fwd_sel_t   fwd_rt,
    input  logic                   load_use,
    stage_slot_if.view             slots,
    input  bypass_pkg::data_word_t rf_rs,
    input  bypass_pkg::data_word_t rf_rt,
    output logic                   operand_valid,
    output bypass_pkg::data_word_t rs_value,
    output bypass_pkg::data_word_t rt_value,
    output logic                   stall_req
);
    import bypass_pkg::*;

    if (DATA_W != $bits(data_word_t)) begin : g_width_check
        $error("operand_mux: DATA_W does not match data_word_t");
    end

    function automatic data_word_t pick_value(
        input fwd_sel_t   sel,
        input data_word_t rf,
        input slot_t      ex_1,
        input slot_t      ex_2,
        input slot_t      mem_1,
        input slot_t      mem_2
    );
        case (sel)
            FWD_EX_ALU_NEW:   return ex_2.alu_res;
            FWD_EX_ALU_OLD:   return ex_1.alu_res;
            FWD_MEM_DATA_NEW: return mem_2.mem_data;
            FWD_MEM_ALU_NEW:  return mem_2.alu_res;
            FWD_MEM_DATA_OLD: return mem_1.mem_data;
            FWD_MEM_ALU_OLD:  return mem_1.alu_res;
            default:          return rf;
        endcase
    endfunction

    data_word_t        rs_d;
    data_word_t        rt_d;
    logic              take;
    logic [DATA_W-1:0] rs_q;
    logic [DATA_W-1:0] rt_q;

    assign rs_d = pick_value(fwd_rs, rf_rs, slots.ex_slot_1, slots.ex_slot_2,
                             slots.mem_slot_1, slots.mem_slot_2);
    assign rt_d = pick_value(fwd_rt, rf_rt, slots.ex_slot_1, slots.ex_slot_2,
                             slots.mem_slot_1, slots.mem_slot_2);
    assign take = query_valid && !load_use;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operand_valid <= 1'b0;
            stall_req     <= 1'b0;
        end else begin
            operand_valid <= take;
            stall_req     <= query_valid && load_use;  // decode repeats the query.
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rs_q <= rs_d;
            rt_q <= rt_d;
        end
    end

    assign rs_value = rs_q;
    assign rt_value = rt_q;

    // a stall must come from a producer that the priority also sees in ex.
    a_stall_from_ex : assert property (
        @(posedge clk) disable iff (!arst_n)
        load_use |-> ((fwd_rs inside {FWD_EX_ALU_NEW, FWD_EX_ALU_OLD})
                   || (fwd_rt inside {FWD_EX_ALU_NEW, FWD_EX_ALU_OLD}))
    );

endmodule

`default_nettype wire

//--- source/forward_unit.sv
`default_nettype none

module forward_unit (
    stage_slot_if.view             slots,
    input  bypass_pkg::reg_addr_t  query_rs,
    input  bypass_pkg::reg_addr_t  query_rt,
    output bypass_pkg::fwd_sel_t   fwd_rs,
    output bypass_pkg::fwd_sel_t   fwd_rt,
    output logic                   load_use
);
    import bypass_pkg::*;

    // ==================================================
    // hazard terms
    // ==================================================

    // register 0 never carries a result, so it never matches.
    function automatic logic hits(input reg_addr_t src, input slot_t s);
        return s.w_ena && (s.w_dst == src) && (src != '0);
    endfunction

    function automatic logic load_hits(input reg_addr_t src, input slot_t s);
        return hits(src, s) && s.ls_ena;
    endfunction

    // ==================================================
    // priority, newest producer first
    // ==================================================

    function automatic fwd_sel_t pick(
        input reg_addr_t src,
        input slot_t     ex_1,
        input slot_t     ex_2,
        input slot_t     mem_1,
        input slot_t     mem_2
    );
        if (hits(src, ex_2)) begin
            return FWD_EX_ALU_NEW;
        end else if (hits(src, ex_1)) begin
            return FWD_EX_ALU_OLD;
        end else if (load_hits(src, mem_2)) begin
            return FWD_MEM_DATA_NEW;
        end else if (hits(src, mem_2)) begin
            return FWD_MEM_ALU_NEW;
        end else if (load_hits(src, mem_1)) begin
            return FWD_MEM_DATA_OLD;
        end else if (hits(src, mem_1)) begin
            return FWD_MEM_ALU_OLD;
        end
        return FWD_NONE;
    endfunction

    assign fwd_rs = pick(query_rs, slots.ex_slot_1, slots.ex_slot_2,
                         slots.mem_slot_1, slots.mem_slot_2);
    assign fwd_rt = pick(query_rt, slots.ex_slot_1, slots.ex_slot_2,
                         slots.mem_slot_1, slots.mem_slot_2);

    // ==================================================
    // load-use, data not back until the memory stage
    // ==================================================

    assign load_use = load_hits(query_rs, slots.ex_slot_1)
                    | load_hits(query_rs, slots.ex_slot_2)
                    | load_hits(query_rt, slots.ex_slot_1)
                    | load_hits(query_rt, slots.ex_slot_2);

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int DATA_W = 32
) (
    input  logic                   clk,
    input  logic                   arst_n,
    stage_slot_if.view             slots,
    input  bypass_pkg::reg_addr_t  rd_addr_1,
    input  bypass_pkg::reg_addr_t  rd_addr_2,
    output bypass_pkg::data_word_t rd_data_1,
    output bypass_pkg::data_word_t rd_data_2
);
    import bypass_pkg::*;

    if (DATA_W != $bits(data_word_t)) begin : g_width_check
        $error("reg_file: DATA_W does not match data_word_t");
    end

    logic [DATA_W-1:0] regs [REG_COUNT];

    logic       wr_en_1;
    logic       wr_en_2;
    data_word_t wb_data_1;
    data_word_t wb_data_2;

    // ==================================================
    // write back from the memory stage
    // ==================================================

    assign wr_en_1   = slots.mem_slot_1.w_ena && (slots.mem_slot_1.w_dst != '0);
    assign wr_en_2   = slots.mem_slot_2.w_ena && (slots.mem_slot_2.w_dst != '0);
    assign wb_data_1 = slots.mem_slot_1.ls_ena ? slots.mem_slot_1.mem_data
                                               : slots.mem_slot_1.alu_res;
    assign wb_data_2 = slots.mem_slot_2.ls_ena ? slots.mem_slot_2.mem_data
                                               : slots.mem_slot_2.alu_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en_1) begin
                regs[slots.mem_slot_1.w_dst] <= wb_data_1;
            end
            if (wr_en_2) begin
                regs[slots.mem_slot_2.w_dst] <= wb_data_2;  // last write, slot 2 wins.
            end
        end
    end

    // no write-through, the forward unit covers the memory stage.
    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];

endmodule

`default_nettype wire

//--- source/slot_pipe.sv
`default_nettype none

module slot_pipe (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_valid,
    input  bypass_pkg::slot_t issue_slot_1,
    input  bypass_pkg::slot_t issue_slot_2,
    stage_slot_if.pipe        slots
);
    import bypass_pkg::*;

    slot_t issue_slot [2];
    slot_t ex_q       [2];
    slot_t mem_q      [2];

    assign issue_slot[0] = issue_slot_1;
    assign issue_slot[1] = issue_slot_2;

    for (genvar i = 0; i < 2; i++) begin : g_slot
        logic       ex_w_ena;
        reg_addr_t  ex_w_dst;
        logic       ex_ls_ena;
        data_word_t ex_alu_res;
        data_word_t ex_mem_data;
        logic       mem_w_ena;
        reg_addr_t  mem_w_dst;
        logic       mem_ls_ena;
        data_word_t mem_alu_res;
        data_word_t mem_mem_data;

        // ==================================================
        // control, an idle cycle issues an empty slot
        // ==================================================

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                ex_w_ena   <= 1'b0;
                ex_w_dst   <= '0;
                ex_ls_ena  <= 1'b0;
                mem_w_ena  <= 1'b0;
                mem_w_dst  <= '0;
                mem_ls_ena <= 1'b0;
            end else begin
                ex_w_ena   <= issue_valid & issue_slot[i].w_ena;
                ex_w_dst   <= issue_valid ? issue_slot[i].w_dst : '0;
                ex_ls_ena  <= issue_valid & issue_slot[i].ls_ena;
                mem_w_ena  <= ex_w_ena;   // memory stage always advances.
                mem_w_dst  <= ex_w_dst;
                mem_ls_ena <= ex_ls_ena;
            end
        end

        // payload only means something while w_ena is set.
        always_ff @(posedge clk) begin
            ex_alu_res   <= issue_slot[i].alu_res;
            ex_mem_data  <= issue_slot[i].mem_data;
            mem_alu_res  <= ex_alu_res;
            mem_mem_data <= ex_mem_data;
        end

        assign ex_q[i]  = '{ex_w_ena, ex_w_dst, ex_ls_ena, ex_alu_res, ex_mem_data};
        assign mem_q[i] = '{mem_w_ena, mem_w_dst, mem_ls_ena, mem_alu_res, mem_mem_data};

        // a load without a write would stall on a result that never lands.
        a_load_writes : assert property (
            @(posedge clk) disable iff (!arst_n)
            ex_q[i].ls_ena |-> ex_q[i].w_ena
        );
    end

    assign slots.ex_slot_1  = ex_q[0];
    assign slots.ex_slot_2  = ex_q[1];
    assign slots.mem_slot_1 = mem_q[0];
    assign slots.mem_slot_2 = mem_q[1];

endmodule

`default_nettype wire

//--- source/stage_slot_if.sv
`default_nettype none

// the four in-flight slots, slot 2 is the younger of each pair.
interface stage_slot_if;
    import bypass_pkg::*;

    slot_t ex_slot_1;
    slot_t ex_slot_2;
    slot_t mem_slot_1;
    slot_t mem_slot_2;

    // stage registers.
    modport pipe (
        output ex_slot_1,
        output ex_slot_2,
        output mem_slot_1,
        output mem_slot_2
    );

    // forwarding, operand select and write back.
    modport view (
        input  ex_slot_1,
        input  ex_slot_2,
        input  mem_slot_1,
        input  mem_slot_2
    );

endinterface

`default_nettype wire

//--- source/bypass_pkg.sv
`default_nettype none

package bypass_pkg;

    // ==================================================
    // widths with a meaning
    // ==================================================

    typedef logic [4:0]  reg_addr_t;   // register number.
    typedef logic [31:0] data_word_t;  // register value.

    localparam int REG_COUNT = 32;

    // ==================================================
    // forward codes
    // ==================================================

    // EX beats MEM, and within a stage the newer slot 2 beats slot 1.
    typedef enum logic [2:0] {
        FWD_NONE         = 3'd0,  // register file.
        FWD_EX_ALU_NEW   = 3'd1,  // ex slot 2 alu result.
        FWD_EX_ALU_OLD   = 3'd2,  // ex slot 1 alu result.
        FWD_MEM_DATA_NEW = 3'd3,  // mem slot 2 load data.
        FWD_MEM_ALU_NEW  = 3'd4,  // mem slot 2 alu result.
        FWD_MEM_DATA_OLD = 3'd5,  // mem slot 1 load data.
        FWD_MEM_ALU_OLD  = 3'd6   // mem slot 1 alu result.
    } fwd_sel_t;

    // ==================================================
    // instruction slot
    // ==================================================

    typedef struct packed {
        logic       w_ena;     // writes a register.
        reg_addr_t  w_dst;     // destination register.
        logic       ls_ena;    // load, result comes from memory.
        data_word_t alu_res;
        data_word_t mem_data;
    } slot_t;

endpackage

`default_nettype wire
